// File: cache/cache_array.sv
`timescale 1ns/100ps
`default_nettype none

// two-way set associative storage, tag compare and victim pick
module cache_array #(
  parameter  int set_bits = 6,
  localparam int tag_w    = mem_sys_pkg::line_addr_w - set_bits,
  localparam int num_sets = 2 ** set_bits,
  localparam int line_w   = mem_sys_pkg::line_w,
  localparam int word_w   = mem_sys_pkg::word_w
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic [set_bits-1:0] set_idx,
  input  logic [tag_w-1:0]    lookup_tag,
  input  logic                fill_en,       // write victim way with fill_line
  input  logic [line_w-1:0]   fill_line,
  input  logic                word_wr_en,    // write one word of the hit way
  input  logic [1:0]          word_sel,
  input  logic [word_w-1:0]   word_data,
  input  logic                touch_en,      // mark touch_way as most recent
  input  logic                touch_way,
  output logic                hit_way_valid,
  output logic                hit_way,
  output logic [line_w-1:0]   rd_line,
  output logic                victim_way,
  output logic                victim_dirty,
  output logic [tag_w-1:0]    victim_tag
);

  ////////////////////////////////////////////////////////////
  // storage
  ////////////////////////////////////////////////////////////
  logic [tag_w-1:0]                tag_mem  [2][num_sets];
  logic [line_w-1:0]               data_mem [2][num_sets];
  logic [1:0][num_sets-1:0]        valid_q;    // per way, per set
  logic [1:0][num_sets-1:0]        dirty_q;
  logic [num_sets-1:0]             lru_q;      // index of the lru way

  logic [1:0] way_hit;
  logic       sel_way;   // way shown on rd_line

  ////////////////////////////////////////////////////////////
  // tag compare, both ways in parallel
  ////////////////////////////////////////////////////////////
  always_comb begin
    for (int w = 0; w < 2; w++) begin
      way_hit[w] = valid_q[w][set_idx] && (tag_mem[w][set_idx] == lookup_tag);
    end
  end

  assign hit_way_valid = |way_hit;
  assign hit_way       = way_hit[1];  // way 0 unless way 1 matched

  // an empty way is taken before the lru one
  always_comb begin
    if (!valid_q[0][set_idx])
      victim_way = 1'b0;
    else if (!valid_q[1][set_idx])
      victim_way = 1'b1;
    else
      victim_way = lru_q[set_idx];
  end

  assign victim_dirty = dirty_q[victim_way][set_idx];  // invalid ways are never dirty
  assign victim_tag   = tag_mem[victim_way][set_idx];

  assign sel_way = hit_way_valid ? hit_way : victim_way;
  assign rd_line = data_mem[sel_way][set_idx];  // hit line, or victim for writeback

  ////////////////////////////////////////////////////////////
  // valid, dirty and lru bits
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= '0;
      dirty_q <= '0;
      lru_q   <= '0;
    end else begin
      if (fill_en) begin
        valid_q[victim_way][set_idx] <= 1'b1;
        dirty_q[victim_way][set_idx] <= 1'b0;  // fresh copy of memory
      end
      if (word_wr_en)
        dirty_q[hit_way][set_idx] <= 1'b1;
      if (touch_en)
        lru_q[set_idx] <= ~touch_way;  // other way becomes lru
    end
  end

  // tag and line data
  always_ff @(posedge clk) begin
    if (fill_en) begin
      data_mem[victim_way][set_idx] <= fill_line;
      tag_mem[victim_way][set_idx]  <= lookup_tag;
    end else if (word_wr_en) begin
      data_mem[hit_way][set_idx][word_sel*word_w +: word_w] <= word_data;
    end
  end

endmodule

`default_nettype wire

// File: cache/cache_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

// request handshake and miss handling for the two-way cache
module cache_ctrl #(
  parameter  int set_bits    = 6,
  localparam int tag_w       = mem_sys_pkg::line_addr_w - set_bits,
  localparam int word_addr_w = mem_sys_pkg::word_addr_w,
  localparam int line_w      = mem_sys_pkg::line_w,
  localparam int word_w      = mem_sys_pkg::word_w
) (
  input  logic                   clk,
  input  logic                   rst_n,
  // requester side
  input  logic                   req,
  input  logic                   we,
  input  logic [word_addr_w-1:0] addr,
  input  logic [word_w-1:0]      wdata,
  output logic                   ack,
  output logic [word_w-1:0]      rdata,
  output logic                   hit,
  // cache array side
  output logic [set_bits-1:0]    set_idx,
  output logic [tag_w-1:0]       lookup_tag,
  output logic                   fill_en,
  output logic [line_w-1:0]      fill_line,
  output logic                   word_wr_en,
  output logic [1:0]             word_sel,
  output logic [word_w-1:0]      word_data,
  output logic                   touch_en,
  output logic                   touch_way,
  input  logic                   hit_way_valid,
  input  logic                   hit_way,
  input  logic [line_w-1:0]      rd_line,
  input  logic                   victim_way,
  input  logic                   victim_dirty,
  input  logic [tag_w-1:0]       victim_tag,
  // memory side
  line_if.ctrl                   mem
);

  mem_sys_pkg::ctrl_state_t state, nxt_state;

  logic [word_addr_w-1:0] addr_q;        // request latched in idle
  logic                   we_q;
  logic [word_w-1:0]      wdata_q;
  logic                   first_lookup;  // hit flag taken only here
  logic                   hit_q;
  logic                   mem_wait;      // memory access issued, rdy not back yet
  logic                   miss;
  logic                   accept;

  ////////////////////////////////////////////////////////////
  // request capture
  ////////////////////////////////////////////////////////////
  assign accept = (state == mem_sys_pkg::idle) && req;

  always_ff @(posedge clk) begin
    if (accept) begin
      addr_q  <= addr;
      we_q    <= we;
      wdata_q <= wdata;
    end
  end

  // address split, word bits at the bottom
  assign word_sel   = addr_q[1:0];
  assign set_idx    = addr_q[set_bits+1:2];
  assign lookup_tag = addr_q[word_addr_w-1:set_bits+2];

  ////////////////////////////////////////////////////////////
  // state machine
  ////////////////////////////////////////////////////////////
  assign miss = (state == mem_sys_pkg::lookup) && !hit_way_valid;

  always_comb begin
    nxt_state = state;
    case (state)
      mem_sys_pkg::idle:
        if (req)
          nxt_state = mem_sys_pkg::lookup;
      mem_sys_pkg::lookup:
        if (hit_way_valid)
          nxt_state = mem_sys_pkg::respond;
        else if (victim_dirty)
          nxt_state = mem_sys_pkg::writeback;  // victim goes out first
        else
          nxt_state = mem_sys_pkg::fill;
      mem_sys_pkg::writeback:
        if (mem_wait && mem.rdy)
          nxt_state = mem_sys_pkg::fill;
      mem_sys_pkg::fill:
        if (fill_en)
          nxt_state = mem_sys_pkg::lookup;     // second lookup now hits
      mem_sys_pkg::respond:
        if (!req)
          nxt_state = mem_sys_pkg::idle;
      default:
        nxt_state = mem_sys_pkg::idle;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state        <= mem_sys_pkg::idle;
      mem_wait     <= 1'b0;
      first_lookup <= 1'b0;
      hit_q        <= 1'b0;
    end else begin
      state    <= nxt_state;
      mem_wait <= (mem_wait && !mem.rdy) || mem.re || mem.we;
      if (accept)
        first_lookup <= 1'b1;
      else if (state == mem_sys_pkg::lookup)
        first_lookup <= 1'b0;
      if ((state == mem_sys_pkg::lookup) && first_lookup)
        hit_q <= hit_way_valid;  // a miss stays reported as miss
    end
  end

  ////////////////////////////////////////////////////////////
  // memory requests
  ////////////////////////////////////////////////////////////
  // writeback straight from lookup; a fill either from lookup or once
  // the writeback has finished
  assign mem.we = miss && victim_dirty;
  assign mem.re = (miss && !victim_dirty) ||
                  ((state == mem_sys_pkg::fill) && !mem_wait);

  assign mem.line_addr = mem.we ? {victim_tag, set_idx} : {lookup_tag, set_idx};
  assign mem.wdata     = rd_line;  // victim line, array untouched until the fill

  ////////////////////////////////////////////////////////////
  // array updates
  ////////////////////////////////////////////////////////////
  assign fill_en    = (state == mem_sys_pkg::fill) && mem_wait && mem.rdy;
  assign fill_line  = mem.rd_data;
  assign word_wr_en = (state == mem_sys_pkg::lookup) && hit_way_valid && we_q;
  assign word_data  = wdata_q;

  // filled way is the newest, so is a hit way
  assign touch_en  = ((state == mem_sys_pkg::lookup) && hit_way_valid) || fill_en;
  assign touch_way = fill_en ? victim_way : hit_way;

  ////////////////////////////////////////////////////////////
  // requester outputs
  ////////////////////////////////////////////////////////////
  assign ack   = (state == mem_sys_pkg::respond);
  assign hit   = hit_q;
  assign rdata = rd_line[word_sel*word_w +: word_w];  // line still hits in respond

endmodule

`default_nettype wire

// File: common/line_if.sv
`timescale 1ns/100ps
`default_nettype none

// line-wide bus between the cache controller and the unified memory
interface line_if;

  logic [mem_sys_pkg::line_addr_w-1:0] line_addr;  // captured by memory on re/we
  logic                                re;         // one cycle pulse, only while rdy
  logic                                we;         // one cycle pulse, only while rdy
  logic [mem_sys_pkg::line_w-1:0]      wdata;      // held for the whole write
  logic [mem_sys_pkg::line_w-1:0]      rd_data;    // valid when rdy returns high
  logic                                rdy;        // low while an access is busy

  modport ctrl (
    output line_addr, re, we, wdata,
    input  rd_data, rdy
  );

  modport mem (
    input  line_addr, re, we, wdata,
    output rd_data, rdy
  );

endinterface

`default_nettype wire

// File: common/mem_sys_pkg.sv
`default_nettype none

package mem_sys_pkg;

  ////////////////////////////////////////////////////////////
  // widths seen at the requester and on the line bus
  ////////////////////////////////////////////////////////////
  localparam int word_addr_w = 16;  // word address at the requester
  localparam int line_addr_w = 14;  // word address without the 2 word bits
  localparam int word_w      = 16;  // requester data width
  localparam int line_w      = 64;  // one cache line, one memory access

  // memory latency, request edge to rdy high
  localparam int mem_access_cycles = 4;

  ////////////////////////////////////////////////////////////
  // cache controller states
  ////////////////////////////////////////////////////////////
  typedef enum logic [2:0] {
    idle,       // waiting for req
    lookup,     // tag compare, hit updates lru and word
    writeback,  // dirty victim going out to memory
    fill,       // missing line coming in from memory
    respond     // ack high until req drops
  } ctrl_state_t;

  ////////////////////////////////////////////////////////////
  // unified memory access states
  ////////////////////////////////////////////////////////////
  typedef enum logic [1:0] {
    mem_idle,   // rdy high, accepts re or we
    mem_write,  // write in progress
    mem_read    // read in progress
  } mem_op_t;

endpackage

`default_nettype wire

// File: hdl/mem_sys.sv
`timescale 1ns/100ps
`default_nettype none

// cached memory system, requester ports to controller, array and memory
module mem_sys #(
  parameter  int set_bits    = 6,  // 64 sets by default
  localparam int tag_w       = mem_sys_pkg::line_addr_w - set_bits,
  localparam int word_addr_w = mem_sys_pkg::word_addr_w,
  localparam int line_w      = mem_sys_pkg::line_w,
  localparam int word_w      = mem_sys_pkg::word_w
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   req,
  input  logic                   we,
  input  logic [word_addr_w-1:0] addr,
  input  logic [word_w-1:0]      wdata,
  output logic                   ack,
  output logic                   hit,
  output logic [word_w-1:0]      rdata
);

  ////////////////////////////////////////////////////////////
  // controller to array
  ////////////////////////////////////////////////////////////
  logic [set_bits-1:0] set_idx;
  logic [tag_w-1:0]    lookup_tag;
  logic                fill_en;
  logic [line_w-1:0]   fill_line;
  logic                word_wr_en;
  logic [1:0]          word_sel;
  logic [word_w-1:0]   word_data;
  logic                touch_en, touch_way;
  logic                hit_way_valid, hit_way;
  logic [line_w-1:0]   rd_line;
  logic                victim_way, victim_dirty;
  logic [tag_w-1:0]    victim_tag;

  line_if line_bus ();  // controller to memory

  cache_ctrl #(.set_bits(set_bits)) ctrl_i (
    .clk, .rst_n, .req, .we, .addr, .wdata, .ack, .rdata, .hit,
    .set_idx, .lookup_tag, .fill_en, .fill_line, .word_wr_en, .word_sel,
    .word_data, .touch_en, .touch_way, .hit_way_valid, .hit_way, .rd_line,
    .victim_way, .victim_dirty, .victim_tag,
    .mem(line_bus)
  );

  cache_array #(.set_bits(set_bits)) array_i (
    .clk, .rst_n, .set_idx, .lookup_tag, .fill_en, .fill_line, .word_wr_en,
    .word_sel, .word_data, .touch_en, .touch_way, .hit_way_valid, .hit_way,
    .rd_line, .victim_way, .victim_dirty, .victim_tag
  );

  unified_mem mem_i (
    .clk,
    .rst_n,
    .bus(line_bus)
  );

endmodule

`default_nettype wire

// File: hdl/unified_mem.sv
`timescale 1ns/100ps
`default_nettype none

// unified memory, line wide, fixed 4 cycle access for reads and writes
module unified_mem (
  input logic  clk,
  input logic  rst_n,
  line_if.mem  bus
);

  localparam int word_addr_w = mem_sys_pkg::word_addr_w;
  localparam int line_addr_w = mem_sys_pkg::line_addr_w;
  localparam int word_w      = mem_sys_pkg::word_w;
  localparam int words       = mem_sys_pkg::line_w / mem_sys_pkg::word_w;  // per line
  localparam int cnt_last    = mem_sys_pkg::mem_access_cycles - 1;

  logic [word_w-1:0]      mem [2**word_addr_w];  // whole space, 16 bits wide
  logic [line_addr_w-1:0] addr_capture;          // held for the whole access
  logic [1:0]             wait_cnt;              // counts the access cycles
  logic                   start;
  logic                   done;                  // last busy cycle

  mem_sys_pkg::mem_op_t state, nxt_state;

  ////////////////////////////////////////////////////////////
  // contents at time zero
  ////////////////////////////////////////////////////////////
  initial begin
    for (int i = 0; i < 2**word_addr_w; i++) begin
      mem[i] = word_w'(i);  // each word holds its own address
    end
  end

  assign start = (state == mem_sys_pkg::mem_idle) && (bus.re || bus.we);

  always_ff @(posedge clk) begin
    if (start)
      addr_capture <= bus.line_addr;
  end

  ////////////////////////////////////////////////////////////
  // access state machine
  ////////////////////////////////////////////////////////////
  always_comb begin
    nxt_state = state;
    done      = 1'b0;
    case (state)
      mem_sys_pkg::mem_idle:
        if (bus.we)
          nxt_state = mem_sys_pkg::mem_write;
        else if (bus.re)
          nxt_state = mem_sys_pkg::mem_read;
      mem_sys_pkg::mem_write, mem_sys_pkg::mem_read:
        if (wait_cnt == 2'(cnt_last)) begin
          done      = 1'b1;
          nxt_state = mem_sys_pkg::mem_idle;
        end
      default:
        nxt_state = mem_sys_pkg::mem_idle;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= mem_sys_pkg::mem_idle;
      wait_cnt <= 2'b00;
    end else begin
      state <= nxt_state;
      if (done || ((state == mem_sys_pkg::mem_idle) && !start))
        wait_cnt <= 2'b00;  // hold at zero between accesses
      else
        wait_cnt <= wait_cnt + 2'b01;
    end
  end

  assign bus.rdy = (state == mem_sys_pkg::mem_idle);  // low the cycle after re/we

  ////////////////////////////////////////////////////////////
  // data path, commits on the edge that ends the access
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (done && (state == mem_sys_pkg::mem_write)) begin
      for (int w = 0; w < words; w++) begin
        mem[{addr_capture, 2'(w)}] <= bus.wdata[w*word_w +: word_w];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (done && (state == mem_sys_pkg::mem_read)) begin
      for (int w = 0; w < words; w++) begin
        bus.rd_data[w*word_w +: word_w] <= mem[{addr_capture, 2'(w)}];  // word 0 lowest
      end
    end
  end

endmodule

`default_nettype wire

// File: mem_sys.f
+incdir+verif
common/mem_sys_pkg.sv
common/line_if.sv
cache/cache_array.sv
cache/cache_ctrl.sv
hdl/unified_mem.sv
hdl/mem_sys.sv
verif/mem_sys_tb.sv

// File: run_sim.sh
#!/bin/sh
# build with Verilator, run, and pass only when the pass line shows up
cd "$(dirname "$0")" &&
  verilator --binary --timing -j 0 --top-module mem_sys_tb -Mdir obj_dir -f mem_sys.f ||
  { echo "build failed"; exit 1; }
out="$(./obj_dir/Vmem_sys_tb 2>&1)"
echo "$out"
echo "$out" | grep -qx "NO ERRORS" &&
  echo "simulation passed" ||
  { echo "simulation failed"; exit 1; }

// File: verif/mem_sys_tb_model.svh
`ifndef mem_sys_tb_model_svh
`define mem_sys_tb_model_svh

////////////////////////////////////////////////////////////
// random source, 32 bit fibonacci lfsr
////////////////////////////////////////////////////////////
logic [31:0] lfsr_q = 32'h54f0_5a1f;

// taps 32, 22, 2, 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
  return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// one lfsr step per bit taken
task automatic draw_bits(input int n, output logic [31:0] val);
  int k;
  val = '0;
  for (k = 0; k < n; k++) begin
    lfsr_q = lfsr_next(lfsr_q);
    val    = {val[30:0], lfsr_q[0]};
  end
endtask

task automatic check_value(input string test, input logic [31:0] expected,
                           input logic [31:0] actual);
  if (actual !== expected)
    abort_run($sformatf("FAIL %s expected %h actual %h", test, expected, actual));
endtask

////////////////////////////////////////////////////////////
// reference memory and tag model
////////////////////////////////////////////////////////////
logic [15:0]      model_mem [65536];     // flat view the requester should see
logic [tag_w-1:0] m_tag     [2][num_sets];
logic             m_valid   [2][num_sets];
logic             m_lru     [num_sets];  // lru way per set

task automatic model_reset();
  int i;
  for (i = 0; i < 65536; i++) begin
    model_mem[i] = 16'(i);  // word holds its own address
  end
  for (i = 0; i < num_sets; i++) begin
    m_valid[0][i] = 1'b0;
    m_valid[1][i] = 1'b0;
    m_lru[i]      = 1'b0;
  end
endtask

// predicts hit flag and read data, then applies the access
task automatic model_access(input logic is_write, input logic [15:0] a,
                           input logic [15:0] d, output logic exp_hit,
                           output logic [15:0] exp_data);
  int               s;
  int               k;
  logic [tag_w-1:0] t;
  logic             way;
  s       = int'(a[set_bits+1:2]);
  t       = a[15:set_bits+2];
  exp_hit = 1'b0;
  way     = 1'b0;
  for (k = 0; k < 2; k++) begin
    if (m_valid[k][s] && (m_tag[k][s] == t)) begin
      exp_hit = 1'b1;
      way     = k[0];
    end
  end
  if (!exp_hit) begin
    if (!m_valid[0][s])
      way = 1'b0;  // empty way first
    else if (!m_valid[1][s])
      way = 1'b1;
    else
      way = m_lru[s];
    m_valid[way][s] = 1'b1;
    m_tag[way][s]   = t;
  end
  m_lru[s] = ~way;  // used way is the newest
  if (is_write)
    model_mem[a] = d;
  exp_data = model_mem[a];
endtask

`endif

// File: verif/mem_sys_tb.sv
`timescale 1ns/100ps
`default_nettype none

module mem_sys_tb;

  localparam int set_bits    = 6;
  localparam int num_sets    = 2 ** set_bits;
  localparam int tag_w       = mem_sys_pkg::line_addr_w - set_bits;
  localparam int n_directed  = 17;    // cold reads, word write, eviction
  localparam int n_random    = 2000;
  localparam int cycle_limit = (n_directed + n_random) * 20 + 200;

  logic        clk;
  logic        rst_n;
  logic        req;
  logic        we;
  logic [15:0] addr;
  logic [15:0] wdata;
  logic        ack;
  logic        hit;
  logic [15:0] rdata;

  int          cycles   = 0;
  logic        req_prev = 1'b0;  // values seen at the last rising edge
  logic        ack_prev = 1'b0;
  logic [15:0] cold_addr [4] = '{16'h1234, 16'h8001, 16'h00fc, 16'hfffe};

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  `include "mem_sys_tb_model.svh"

  mem_sys #(.set_bits(set_bits)) dut_i (
    .clk, .rst_n, .req, .we, .addr, .wdata, .ack, .hit, .rdata
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;  // 10 ns

  ////////////////////////////////////////////////////////////
  // timeout and handshake monitor
  ////////////////////////////////////////////////////////////
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= cycle_limit)
      abort_run($sformatf("timeout, run still going after %0d cycles", cycle_limit));
  end

  always @(posedge clk) begin
    if (rst_n) begin
      if (ack && !ack_prev && !req_prev)
        abort_run("ack rose while req was low");
      if (!ack && ack_prev && req_prev)
        abort_run("ack fell while req was still high");
      if (req && !req_prev && ack)
        abort_run("req raised again before ack fell");
    end
    req_prev = req;
    ack_prev = ack;
  end

  ////////////////////////////////////////////////////////////
  // four phase requester
  ////////////////////////////////////////////////////////////
  task automatic access(input string name, input logic is_write,
                        input logic [15:0] a, input logic [15:0] d);
    logic        exp_hit;
    logic [15:0] exp_data;
    logic        got_hit;
    logic [15:0] got_data;
    logic [31:0] gap;
    logic [31:0] hold;
    draw_bits(2, gap);          // 0 to 3 idle cycles
    repeat (int'(gap)) @(negedge clk);
    model_access(is_write, a, d, exp_hit, exp_data);
    req   = 1'b1;
    we    = is_write;
    addr  = a;
    wdata = d;
    @(negedge clk);
    while (!ack) @(negedge clk);
    got_hit  = hit;             // held through respond
    got_data = rdata;
    draw_bits(2, hold);         // req stays up 0 to 3 more cycles
    repeat (int'(hold)) @(negedge clk);
    req      = 1'b0;
    @(negedge clk);
    while (ack) @(negedge clk);
    check_value({name, " hit"}, 32'(exp_hit), 32'(got_hit));
    if (!is_write)
      check_value({name, " rdata"}, 32'(exp_data), 32'(got_data));
  endtask

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////
  initial begin
    int          n;
    logic [31:0] r_tag;
    logic [31:0] r_set;
    logic [31:0] r_word;
    logic [31:0] r_we;
    logic [31:0] r_data;
    req   = 1'b0;
    we    = 1'b0;
    addr  = '0;
    wdata = '0;
    rst_n = 1'b0;
    model_reset();
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    check_value("reset ack", 32'd0, 32'(ack));
    check_value("reset hit", 32'd0, 32'(hit));

    // cold misses return the fill pattern, rereads hit
    for (n = 0; n < 4; n++) begin
      access("cold read", 1'b0, cold_addr[n], 16'h0000);
      access("reread", 1'b0, cold_addr[n], 16'h0000);
    end

    // one word written, neighbours untouched
    access("word write", 1'b1, 16'h1235, 16'hbeef);
    access("readback", 1'b0, 16'h1235, 16'h0000);
    access("neighbour 0", 1'b0, 16'h1234, 16'h0000);
    access("neighbour 2", 1'b0, 16'h1236, 16'h0000);
    access("neighbour 3", 1'b0, 16'h1237, 16'h0000);

    // set 0x0d, tags 0x12 0x22 0x32 push the dirty line out
    access("evict write", 1'b1, 16'h1234, 16'ha5a5);
    access("conflict a", 1'b0, 16'h2234, 16'h0000);
    access("conflict b", 1'b0, 16'h3234, 16'h0000);
    access("evicted readback", 1'b0, 16'h1234, 16'h0000);

    // 4 tags x 8 sets, lots of conflicts
    for (n = 0; n < n_random; n++) begin
      draw_bits(2, r_tag);
      draw_bits(3, r_set);
      draw_bits(2, r_word);
      draw_bits(1, r_we);
      draw_bits(16, r_data);
      access("random", r_we[0],
             {6'b101100, r_tag[1:0], 3'b011, r_set[2:0], r_word[1:0]}, r_data[15:0]);
    end

    $display("NO ERRORS");
    $finish;
  end

endmodule

`default_nettype wire
